//--- mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;		// Register, operand, data and instruction word
	typedef logic [31:0] addr_t;		// Word address for PC and data
	typedef logic [4:0] reg_addr_t;		// Register index
	typedef logic [5:0] opcode_t;		// Instruction bits 31:26
	typedef logic [5:0] funct_t;		// Instruction bits 5:0

	typedef enum logic [1:0] {PC_BRANCH = 2'd0, PC_JUMP = 2'd1, PC_REG = 2'd2, PC_NEXT = 2'd3} pc_src_t;
	typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_RA = 2'd2} reg_dst_t;
	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_RA = 2'd2, WB_MUU = 2'd3} wb_src_t;
	typedef enum logic [1:0] {WE_NONE = 2'd0, WE_ALWAYS = 2'd1, WE_COND = 2'd2} reg_we_t;

	// ALU request from the control unit
	typedef enum logic [3:0] {
		ALUOP_ADD = 4'd0,
		ALUOP_SUB = 4'd1,
		ALUOP_AND = 4'd2,
		ALUOP_OR = 4'd4,
		ALUOP_XOR = 4'd5,
		ALUOP_FUNCT = 4'd6,				// Look at funct field
		ALUOP_GEZ = 4'd7,
		ALUOP_LUI = 4'd9
	} alu_op_t;

	// Operation the ALU actually performs
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_LUI, ALU_GEZ, ALU_PASS_B
	} alu_fn_t;

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_REGIMM = 6'h01;		// BGEZ and BGEZAL chosen by rt
	localparam opcode_t OP_J = 6'h02;
	localparam opcode_t OP_JAL = 6'h03;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_BNE = 6'h05;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_ANDI = 6'h0c;
	localparam opcode_t OP_ORI = 6'h0d;
	localparam opcode_t OP_XORI = 6'h0e;
	localparam opcode_t OP_LUI = 6'h0f;
	localparam opcode_t OP_SPECIAL2 = 6'h1c;	// MUL, MADD, MSUBU
	localparam opcode_t OP_LB = 6'h20;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SB = 6'h28;
	localparam opcode_t OP_SW = 6'h2b;

	localparam funct_t FN_JR = 6'h08;
	localparam funct_t FN_JALR = 6'h09;
	localparam funct_t FN_MOVN = 6'h0b;
	localparam funct_t FN_MFHI = 6'h10;
	localparam funct_t FN_MFLO = 6'h12;
	localparam funct_t FN_MULT = 6'h18;
	localparam funct_t FN_MULTU = 6'h19;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;
	localparam funct_t FN_SLTU = 6'h2b;
	localparam funct_t FN_MADD = 6'h00;		// SPECIAL2 functs
	localparam funct_t FN_MUL = 6'h02;
	localparam funct_t FN_MSUBU = 6'h05;

	localparam reg_addr_t RT_BGEZ = 5'h01;		// REGIMM variants in rt
	localparam reg_addr_t RT_BGEZAL = 5'h11;
	localparam reg_addr_t RA_INDEX = 5'd31;		// Link register

endpackage

//--- control_unit.sv
`timescale 1ns/1ns

module control_unit
(
	input mips_pkg::opcode_t opcode,		// Instruction opcode
	input mips_pkg::funct_t funct,			// R-type and SPECIAL2 function
	input mips_pkg::reg_addr_t rt,			// Selects BGEZ or BGEZAL
	output mips_pkg::pc_src_t pc_src,		// Next PC source
	output mips_pkg::reg_dst_t reg_dst,		// Destination register choice
	output mips_pkg::wb_src_t reg_write,		// Write-back data source
	output mips_pkg::alu_op_t op_alu,		// Requested ALU operation
	output logic write_enable_mem,			// Data memory store
	output logic orig_alu,				// Second operand is the immediate
	output mips_pkg::reg_we_t write_enable_reg,	// Register write mode
	output logic equal,				// Branch when flag equals this
	output logic signed_imm_extension,		// Sign or zero extend immediate
	output logic mem_byte_mode			// Byte access instead of word
);

	always_comb
	begin
		pc_src = mips_pkg::PC_NEXT;		// Plain PC+1 unless decoded otherwise
		reg_dst = mips_pkg::DST_RT;
		reg_write = mips_pkg::WB_ALU;
		op_alu = mips_pkg::ALUOP_ADD;
		write_enable_mem = 1'b0;
		orig_alu = 1'b0;
		write_enable_reg = mips_pkg::WE_NONE;	// Unknown opcodes write nothing
		equal = 1'b1;
		signed_imm_extension = 1'b1;
		mem_byte_mode = 1'b0;

		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				reg_dst = mips_pkg::DST_RD;		// Three register form
				op_alu = mips_pkg::ALUOP_FUNCT;		// ALU control reads funct
				case (funct)
					mips_pkg::FN_JR:
						pc_src = mips_pkg::PC_REG;	// PC = rs
					mips_pkg::FN_JALR:
					begin
						pc_src = mips_pkg::PC_REG;
						reg_dst = mips_pkg::DST_RA;	// Link into $ra
						reg_write = mips_pkg::WB_RA;
						write_enable_reg = mips_pkg::WE_ALWAYS;
					end
					mips_pkg::FN_MOVN:
						write_enable_reg = mips_pkg::WE_COND;	// Only when rt is non-zero
					mips_pkg::FN_MFHI, mips_pkg::FN_MFLO,
					mips_pkg::FN_MULT, mips_pkg::FN_MULTU:
					begin
						reg_write = mips_pkg::WB_MUU;		// Multiply unit result
						write_enable_reg = mips_pkg::WE_COND;	// Unit decides
					end
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
					mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
					mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT,
					mips_pkg::FN_SLTU:
						write_enable_reg = mips_pkg::WE_ALWAYS;
					default:
						write_enable_reg = mips_pkg::WE_NONE;	// Shifts not supported
				endcase
			end

			mips_pkg::OP_SPECIAL2:
			begin
				reg_dst = mips_pkg::DST_RD;
				case (funct)
					mips_pkg::FN_MUL, mips_pkg::FN_MADD, mips_pkg::FN_MSUBU:
					begin
						reg_write = mips_pkg::WB_MUU;
						write_enable_reg = mips_pkg::WE_COND;	// Only MUL writes rd
					end
					default:
						write_enable_reg = mips_pkg::WE_NONE;
				endcase
			end

			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU:
			begin
				orig_alu = 1'b1;			// Add sign extended immediate
				write_enable_reg = mips_pkg::WE_ALWAYS;
			end

			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI:
			begin
				orig_alu = 1'b1;
				signed_imm_extension = 1'b0;		// Logic immediates zero extend
				write_enable_reg = mips_pkg::WE_ALWAYS;
				case (opcode)
					mips_pkg::OP_ANDI: op_alu = mips_pkg::ALUOP_AND;
					mips_pkg::OP_ORI: op_alu = mips_pkg::ALUOP_OR;
					mips_pkg::OP_XORI: op_alu = mips_pkg::ALUOP_XOR;
					default: op_alu = mips_pkg::ALUOP_LUI;
				endcase
			end

			mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
			begin
				pc_src = mips_pkg::PC_BRANCH;
				op_alu = mips_pkg::ALUOP_SUB;		// Zero flag compares rs and rt
				equal = (opcode == mips_pkg::OP_BEQ);	// BNE branches on flag low
			end

			mips_pkg::OP_REGIMM:
			begin
				op_alu = mips_pkg::ALUOP_GEZ;		// Flag is rs >= 0
				orig_alu = 1'b1;
				case (rt)
					mips_pkg::RT_BGEZ:
						pc_src = mips_pkg::PC_BRANCH;
					mips_pkg::RT_BGEZAL:
					begin
						pc_src = mips_pkg::PC_BRANCH;
						reg_dst = mips_pkg::DST_RA;	// Links even when not taken
						reg_write = mips_pkg::WB_RA;
						write_enable_reg = mips_pkg::WE_ALWAYS;
					end
					default:
						pc_src = mips_pkg::PC_NEXT;	// Other REGIMM forms ignored
				endcase
			end

			mips_pkg::OP_LW, mips_pkg::OP_LB:
			begin
				orig_alu = 1'b1;			// Address is rs + offset
				reg_write = mips_pkg::WB_MEM;
				write_enable_reg = mips_pkg::WE_ALWAYS;
				mem_byte_mode = (opcode == mips_pkg::OP_LB);
			end

			mips_pkg::OP_SW, mips_pkg::OP_SB:
			begin
				orig_alu = 1'b1;
				write_enable_mem = 1'b1;
				mem_byte_mode = (opcode == mips_pkg::OP_SB);
			end

			mips_pkg::OP_J:
				pc_src = mips_pkg::PC_JUMP;

			mips_pkg::OP_JAL:
			begin
				pc_src = mips_pkg::PC_JUMP;
				reg_dst = mips_pkg::DST_RA;		// Return address to $ra
				reg_write = mips_pkg::WB_RA;
				write_enable_reg = mips_pkg::WE_ALWAYS;
			end

			default:
				pc_src = mips_pkg::PC_NEXT;
		endcase
	end

endmodule

//--- alu_control.sv
`timescale 1ns/1ns

module alu_control
(
	input mips_pkg::alu_op_t op_alu,	// Request from control unit
	input mips_pkg::funct_t funct,		// R-type function field
	output mips_pkg::alu_fn_t alu_fn	// Operation for the ALU
);

	always_comb
	begin
		case (op_alu)
			mips_pkg::ALUOP_ADD: alu_fn = mips_pkg::ALU_ADD;
			mips_pkg::ALUOP_SUB: alu_fn = mips_pkg::ALU_SUB;
			mips_pkg::ALUOP_AND: alu_fn = mips_pkg::ALU_AND;
			mips_pkg::ALUOP_OR: alu_fn = mips_pkg::ALU_OR;
			mips_pkg::ALUOP_XOR: alu_fn = mips_pkg::ALU_XOR;
			mips_pkg::ALUOP_GEZ: alu_fn = mips_pkg::ALU_GEZ;
			mips_pkg::ALUOP_LUI: alu_fn = mips_pkg::ALU_LUI;
			mips_pkg::ALUOP_FUNCT:
			begin
				case (funct)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU:
						alu_fn = mips_pkg::ALU_ADD;	// No overflow trap
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU:
						alu_fn = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_fn = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: alu_fn = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_fn = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_fn = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_fn = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_fn = mips_pkg::ALU_SLTU;
					mips_pkg::FN_MOVN:
						alu_fn = mips_pkg::ALU_PASS_B;	// Moves rs to rd
					default:
						alu_fn = mips_pkg::ALU_ADD;	// JR, JALR and multiply functs
				endcase
			end
			default: alu_fn = mips_pkg::ALU_ADD;
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu
(
	input mips_pkg::word_t a,		// rs value
	input mips_pkg::word_t b,		// rt value or immediate
	input mips_pkg::alu_fn_t alu_fn,	// Operation select
	output mips_pkg::word_t result,		// Operation result
	output logic flag			// Branch condition
);

	always_comb
	begin
		case (alu_fn)
			mips_pkg::ALU_ADD:
				result = a + b;
			mips_pkg::ALU_SUB:
				result = a - b;
			mips_pkg::ALU_AND:
				result = a & b;
			mips_pkg::ALU_OR:
				result = a | b;
			mips_pkg::ALU_XOR:
				result = a ^ b;
			mips_pkg::ALU_NOR:
				result = ~(a | b);
			mips_pkg::ALU_SLT:
				result = {31'b0, $signed(a) < $signed(b)};	// Signed compare
			mips_pkg::ALU_SLTU:
				result = {31'b0, a < b};
			mips_pkg::ALU_LUI:
				result = {b[15:0], 16'b0};	// Immediate to upper half
			mips_pkg::ALU_GEZ:
				result = {31'b0, ~a[31]};
			mips_pkg::ALU_PASS_B:
				result = a;			// MOVN carries rs through
			default:
				result = a + b;
		endcase
	end

	// Zero test serves BEQ/BNE, sign test serves BGEZ
	always_comb
	begin
		if (alu_fn == mips_pkg::ALU_GEZ)
			flag = ~a[31];
		else
			flag = (result == '0);
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file
(
	input logic clk,
	input logic reset,
	input mips_pkg::reg_addr_t rs_addr,	// First read port
	input mips_pkg::reg_addr_t rt_addr,	// Second read port
	input mips_pkg::reg_addr_t wr_addr,	// Write port index
	input mips_pkg::word_t wr_data,
	input logic wr_en,
	output mips_pkg::word_t rs_data,
	output mips_pkg::word_t rt_data
);

	mips_pkg::word_t regs [32];		// General registers

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;		// Whole file starts at zero
		end
		else if (wr_en && wr_addr != '0)	// $zero is never written
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Asynchronous reads, $zero forced
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- mul_unit.sv
`timescale 1ns/1ns

module mul_unit
(
	input logic clk,
	input logic reset,
	input mips_pkg::opcode_t opcode,	// RTYPE or SPECIAL2
	input mips_pkg::funct_t funct,
	input mips_pkg::word_t a,		// rs
	input mips_pkg::word_t b,		// rt
	input logic enable,			// Instruction belongs to this unit
	output mips_pkg::word_t result,		// MFHI, MFLO or MUL value
	output logic writes_reg			// Instruction writes rd
);

	mips_pkg::word_t hi;
	mips_pkg::word_t lo;
	logic signed [63:0] prod_s;		// Signed 64-bit product
	logic [63:0] prod_u;			// Unsigned 64-bit product
	logic is_special2;

	assign prod_s = $signed(a) * $signed(b);
	assign prod_u = {32'b0, a} * {32'b0, b};
	assign is_special2 = (opcode == mips_pkg::OP_SPECIAL2);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (enable)
		begin
			if (is_special2 && funct == mips_pkg::FN_MADD)
				{hi, lo} <= {hi, lo} + prod_s;	// Signed accumulate
			else if (is_special2 && funct == mips_pkg::FN_MSUBU)
				{hi, lo} <= {hi, lo} - prod_u;	// Unsigned subtract
			else if (!is_special2 && funct == mips_pkg::FN_MULT)
				{hi, lo} <= prod_s;
			else if (!is_special2 && funct == mips_pkg::FN_MULTU)
				{hi, lo} <= prod_u;
		end
	end

	always_comb
	begin
		result = lo;
		writes_reg = 1'b0;
		if (enable && is_special2 && funct == mips_pkg::FN_MUL)
		begin
			result = prod_s[31:0];		// Low word, HI/LO untouched
			writes_reg = 1'b1;
		end
		else if (enable && !is_special2 && funct == mips_pkg::FN_MFHI)
		begin
			result = hi;
			writes_reg = 1'b1;
		end
		else if (enable && !is_special2 && funct == mips_pkg::FN_MFLO)
			writes_reg = 1'b1;		// Result already lo
	end

endmodule

//--- mips_core.sv
`timescale 1ns/1ns

module mips_core
(
	input logic clk,
	input logic reset,
	input mips_pkg::word_t instr,		// Instruction at pc, same cycle
	input mips_pkg::word_t mem_rdata,	// Data memory read, combinational
	output mips_pkg::addr_t pc,		// Word address of instruction
	output mips_pkg::addr_t mem_addr,
	output mips_pkg::word_t mem_wdata,
	output logic mem_we,			// Store this cycle
	output logic mem_byte			// Low byte access
);

	mips_pkg::opcode_t opcode;
	mips_pkg::funct_t funct;
	mips_pkg::reg_addr_t rs_addr;
	mips_pkg::reg_addr_t rt_addr;
	mips_pkg::reg_addr_t rd_addr;
	mips_pkg::reg_addr_t wr_addr;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;
	mips_pkg::word_t muu_result;
	mips_pkg::word_t wb_data;
	mips_pkg::addr_t pc_plus1;
	mips_pkg::addr_t branch_target;
	mips_pkg::addr_t jump_target;
	mips_pkg::addr_t pc_next;
	mips_pkg::pc_src_t pc_src;
	mips_pkg::reg_dst_t reg_dst;
	mips_pkg::wb_src_t reg_write;
	mips_pkg::alu_op_t op_alu;
	mips_pkg::alu_fn_t alu_fn;
	mips_pkg::reg_we_t write_enable_reg;
	logic write_enable_mem;
	logic orig_alu;
	logic equal;
	logic signed_imm_extension;
	logic mem_byte_mode;
	logic flag;
	logic muu_writes;
	logic cond_ok;				// Condition for WE_COND writes
	logic wr_en;

	assign opcode = instr[31:26];
	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];
	assign rd_addr = instr[15:11];
	assign funct = instr[5:0];
	assign imm_ext = signed_imm_extension ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
	assign alu_b = orig_alu ? imm_ext : rt_data;

	assign pc_plus1 = pc + 32'd1;			// Word addressed
	assign branch_target = pc_plus1 + imm_ext;
	assign jump_target = {pc_plus1[31:26], instr[25:0]};

	always_comb
	begin
		case (pc_src)
			mips_pkg::PC_BRANCH: pc_next = (flag == equal) ? branch_target : pc_plus1;
			mips_pkg::PC_JUMP: pc_next = jump_target;
			mips_pkg::PC_REG: pc_next = rs_data;	// JR, JALR
			default: pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	always_comb
	begin
		case (reg_dst)
			mips_pkg::DST_RD: wr_addr = rd_addr;
			mips_pkg::DST_RA: wr_addr = mips_pkg::RA_INDEX;
			default: wr_addr = rt_addr;
		endcase
		case (reg_write)
			mips_pkg::WB_MEM: wb_data = mem_byte_mode ? {{24{mem_rdata[7]}}, mem_rdata[7:0]} : mem_rdata;
			mips_pkg::WB_RA: wb_data = pc_plus1;	// Return address
			mips_pkg::WB_MUU: wb_data = muu_result;
			default: wb_data = alu_result;
		endcase
	end

	// MOVN checks rt, multiply ops ask the unit
	assign cond_ok = (reg_write == mips_pkg::WB_MUU) ? muu_writes : (rt_data != '0);
	assign wr_en = !reset && (write_enable_reg == mips_pkg::WE_ALWAYS ||
		(write_enable_reg == mips_pkg::WE_COND && cond_ok));

	assign mem_addr = alu_result;			// rs + offset
	assign mem_wdata = rt_data;
	assign mem_we = write_enable_mem && !reset;	// No stores during reset
	assign mem_byte = mem_byte_mode;

	control_unit i_control_unit
	(
		.opcode(opcode), .funct(funct), .rt(rt_addr),
		.pc_src(pc_src), .reg_dst(reg_dst), .reg_write(reg_write), .op_alu(op_alu),
		.write_enable_mem(write_enable_mem), .orig_alu(orig_alu),
		.write_enable_reg(write_enable_reg), .equal(equal),
		.signed_imm_extension(signed_imm_extension), .mem_byte_mode(mem_byte_mode)
	);

	alu_control i_alu_control (.op_alu(op_alu), .funct(funct), .alu_fn(alu_fn));

	alu i_alu (.a(rs_data), .b(alu_b), .alu_fn(alu_fn), .result(alu_result), .flag(flag));

	reg_file i_reg_file
	(
		.clk(clk), .reset(reset), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.wr_addr(wr_addr), .wr_data(wb_data), .wr_en(wr_en),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	mul_unit i_mul_unit
	(
		.clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
		.a(rs_data), .b(rt_data), .enable(reg_write == mips_pkg::WB_MUU),
		.result(muu_result), .writes_reg(muu_writes)
	);

endmodule

//--- tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core;

	localparam int RESET_CYCLES = 10;		// Reset length before every test
	localparam int RESET_HOLD_CYCLES = 3;
	localparam int ALU_CYCLES = 26;
	localparam int MEM_CYCLES = 12;
	localparam int BRANCH_CYCLES = 13;
	localparam int JUMP_CYCLES = 10;
	localparam int MOVN_CYCLES = 7;
	localparam int MUL_CYCLES = 28;
	localparam int TOTAL_CYCLES = 7 * RESET_CYCLES + RESET_HOLD_CYCLES + ALU_CYCLES +
		MEM_CYCLES + BRANCH_CYCLES + JUMP_CYCLES + MOVN_CYCLES + MUL_CYCLES;

	logic clk;
	logic reset;
	mips_pkg::word_t instr;
	mips_pkg::word_t mem_rdata;
	mips_pkg::addr_t pc;
	mips_pkg::addr_t mem_addr;
	mips_pkg::word_t mem_wdata;
	logic mem_we;
	logic mem_byte;

	mips_pkg::word_t imem [256] = '{default: '0};	// Instruction memory, word addressed
	mips_pkg::word_t dmem [256] = '{default: '0};	// Data memory, word addressed
	mips_pkg::addr_t pc_q [$];			// PC of every retired instruction
	mips_pkg::addr_t store_addr_q [$];		// Stores seen at the data port
	mips_pkg::word_t store_data_q [$];
	int prog_len;
	int errors;
	int checks;
	integer seed;

	mips_core i_dut
	(
		.clk(clk), .reset(reset), .instr(instr), .mem_rdata(mem_rdata),
		.pc(pc), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_we(mem_we), .mem_byte(mem_byte)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;			// 20 ns period
	end

	assign instr = imem[pc[7:0]];			// Answers within the cycle
	assign mem_rdata = dmem[mem_addr[7:0]];	// Whole word, core picks the byte

	// Memory writes and trace capture, cleared while reset is high
	always @(posedge clk)
	begin
		if (reset)
		begin
			pc_q.delete();
			store_addr_q.delete();
			store_data_q.delete();
			for (int i = 0; i < 256; i++)
				dmem[i] <= '0;
		end
		else
		begin
			pc_q.push_back(pc);
			if (mem_we)
			begin
				store_addr_q.push_back(mem_addr);
				store_data_q.push_back(mem_wdata);
				if (mem_byte)
					dmem[mem_addr[7:0]][7:0] <= mem_wdata[7:0];	// Low byte only
				else
					dmem[mem_addr[7:0]] <= mem_wdata;
			end
		end
	end

	initial
	begin
		#(TOTAL_CYCLES * 2 * 20);
		$display("Timeout: the run went past the length of all tests");
		$display("Test failures found");
		$finish;
	end

	function automatic mips_pkg::word_t r_type(mips_pkg::funct_t fn, int rs, int rt, int rd);
		return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
	endfunction

	function automatic mips_pkg::word_t sp2_type(mips_pkg::funct_t fn, int rs, int rt, int rd);
		return {mips_pkg::OP_SPECIAL2, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
	endfunction

	function automatic mips_pkg::word_t i_type(mips_pkg::opcode_t op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};	// Negative offsets wrap to 16 bits
	endfunction

	function automatic mips_pkg::word_t j_type(mips_pkg::opcode_t op, int index);
		return {op, 26'(index)};
	endfunction

	// Reference results from the instruction definitions
	function automatic mips_pkg::word_t expected_alu(mips_pkg::funct_t fn, mips_pkg::word_t x,
		mips_pkg::word_t y);
		case (fn)
			mips_pkg::FN_ADDU: return x + y;
			mips_pkg::FN_SUB: return x - y;
			mips_pkg::FN_AND: return x & y;
			mips_pkg::FN_OR: return x | y;
			mips_pkg::FN_XOR: return x ^ y;
			mips_pkg::FN_NOR: return ~(x | y);
			mips_pkg::FN_SLT: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			mips_pkg::FN_SLTU: return (x < y) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic logic [63:0] wide_product(mips_pkg::word_t x, mips_pkg::word_t y,
		logic is_signed);
		if (is_signed)
			return {{32{x[31]}}, x} * {{32{y[31]}}, y};	// Low 64 bits of signed product
		else
			return {32'b0, x} * {32'b0, y};
	endfunction

	task automatic put_instr(mips_pkg::word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_const(int rd, mips_pkg::word_t v);
		put_instr(i_type(mips_pkg::OP_LUI, 0, rd, int'(v[31:16])));
		put_instr(i_type(mips_pkg::OP_ORI, rd, rd, int'(v[15:0])));
	endtask

	task automatic begin_test();
		reset = 1'b1;				// Core idles while the program loads
		prog_len = 0;
		for (int i = 0; i < 256; i++)
			imem[i] = '0;			// Unused slots decode as no-ops
	endtask

	task automatic release_reset(string name);
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			check_addr({name, " reset pc"}, '0, pc);
			checks++;
			if (mem_we !== 1'b0)
			begin
				errors++;
				$display("%s: store enabled while reset is held", name);
			end
		end
		reset = 1'b0;
	endtask

	task automatic run_cycles(int n);
		repeat (n) @(negedge clk);		// One instruction per cycle
	endtask

	task automatic check_word(string name, mips_pkg::word_t expected, mips_pkg::word_t actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(string name, mips_pkg::addr_t expected, mips_pkg::addr_t actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Fail %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_store_count(string name, int n);
		check_word({name, " store count"}, 32'(n), 32'(store_addr_q.size()));
	endtask

	task automatic expect_store(string name, int idx, mips_pkg::addr_t addr, mips_pkg::word_t data);
		if (idx >= store_addr_q.size())
		begin
			checks++;
			errors++;
			$display("%s: store %0d never reached the data port", name, idx);
		end
		else
		begin
			check_addr({name, " store address"}, addr, store_addr_q[idx]);
			check_word({name, " store data"}, data, store_data_q[idx]);
		end
	endtask

	task automatic check_pc(string name, int idx, mips_pkg::addr_t expected);
		if (idx >= pc_q.size())
		begin
			checks++;
			errors++;
			$display("%s: instruction %0d was never fetched", name, idx);
		end
		else
			check_addr({name, " pc"}, expected, pc_q[idx]);
	endtask

	task automatic reset_hold_test();
		begin_test();
		put_instr(i_type(mips_pkg::OP_SW, 0, 0, 90));	// Store sits at pc 0 during reset
		put_instr(i_type(mips_pkg::OP_ORI, 0, 0, 16'hffff));	// $zero stays zero
		put_instr(i_type(mips_pkg::OP_SW, 0, 0, 91));
		release_reset("reset hold");
		run_cycles(RESET_HOLD_CYCLES);
		check_store_count("reset hold", 2);
		expect_store("reset hold", 0, 90, '0);
		expect_store("reset hold", 1, 91, '0);
	endtask

	task automatic alu_test();
		mips_pkg::funct_t fns [8];
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		logic [15:0] k;
		fns = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_AND, mips_pkg::FN_OR,
			mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
		a = $random(seed);
		b = $random(seed);
		k = 16'($random(seed));
		begin_test();
		load_const(1, a);
		load_const(2, b);
		for (int i = 0; i < 8; i++)
		begin
			put_instr(r_type(fns[i], 1, 2, 3));
			put_instr(i_type(mips_pkg::OP_SW, 0, 3, i));	// Result i to word i
		end
		put_instr(i_type(mips_pkg::OP_ANDI, 1, 3, int'(k)));
		put_instr(i_type(mips_pkg::OP_SW, 0, 3, 8));
		put_instr(i_type(mips_pkg::OP_XORI, 1, 3, int'(k)));
		put_instr(i_type(mips_pkg::OP_SW, 0, 3, 9));
		put_instr(i_type(mips_pkg::OP_ADDI, 1, 3, int'(k)));	// Sign extended
		put_instr(i_type(mips_pkg::OP_SW, 0, 3, 10));
		release_reset("alu");
		run_cycles(ALU_CYCLES);
		check_store_count("alu", 11);
		for (int i = 0; i < 8; i++)
			expect_store("alu", i, i, expected_alu(fns[i], a, b));
		expect_store("alu andi", 8, 8, a & {16'b0, k});
		expect_store("alu xori", 9, 9, a ^ {16'b0, k});
		expect_store("alu addi", 10, 10, a + {{16{k[15]}}, k});
	endtask

	task automatic memory_test();
		mips_pkg::word_t d;
		logic [15:0] v;
		d = $random(seed);
		v = 16'($random(seed)) | 16'h0080;	// Negative low byte
		begin_test();
		load_const(1, d);
		put_instr(i_type(mips_pkg::OP_SW, 0, 1, 20));
		put_instr(i_type(mips_pkg::OP_LW, 0, 2, 20));
		put_instr(i_type(mips_pkg::OP_SW, 0, 2, 21));	// Word round trip
		put_instr(i_type(mips_pkg::OP_SW, 0, 1, 30));
		put_instr(i_type(mips_pkg::OP_ORI, 0, 3, int'(v)));
		put_instr(i_type(mips_pkg::OP_SB, 0, 3, 30));	// Overwrites low byte only
		put_instr(i_type(mips_pkg::OP_LW, 0, 5, 30));
		put_instr(i_type(mips_pkg::OP_SW, 0, 5, 31));
		put_instr(i_type(mips_pkg::OP_LB, 0, 6, 30));
		put_instr(i_type(mips_pkg::OP_SW, 0, 6, 32));
		release_reset("memory");
		run_cycles(MEM_CYCLES);
		check_store_count("memory", 6);
		expect_store("memory sw", 0, 20, d);
		expect_store("memory lw", 1, 21, d);
		expect_store("memory sw", 2, 30, d);
		expect_store("memory sb", 3, 30, {16'b0, v});
		expect_store("memory sb word", 4, 31, {d[31:8], v[7:0]});
		expect_store("memory lb", 5, 32, {24'hffffff, v[7:0]});
	endtask

	task automatic branch_test();
		int trace [13] = '{0, 1, 2, 5, 6, 7, 9, 10, 11, 12, 16, 20, 17};
		mips_pkg::word_t fill;
		fill = i_type(mips_pkg::OP_SW, 0, 0, 50);	// Any run of a skipped slot shows up
		begin_test();
		put_instr(i_type(mips_pkg::OP_ORI, 0, 1, 5));
		put_instr(i_type(mips_pkg::OP_ORI, 0, 2, 5));
		put_instr(i_type(mips_pkg::OP_BEQ, 1, 2, 2));	// Taken to 5
		put_instr(fill);
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_BNE, 1, 2, 3));	// Not taken
		put_instr(i_type(mips_pkg::OP_ORI, 0, 3, 7));
		put_instr(i_type(mips_pkg::OP_BNE, 1, 3, 1));	// Taken to 9
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_BEQ, 1, 3, 4));	// Not taken
		put_instr(i_type(mips_pkg::OP_LUI, 0, 4, 16'h8000));
		put_instr(i_type(mips_pkg::OP_REGIMM, 4, int'(mips_pkg::RT_BGEZ), 2));	// rs < 0
		put_instr(i_type(mips_pkg::OP_REGIMM, 1, int'(mips_pkg::RT_BGEZ), 3));	// To 16
		put_instr(fill);
		put_instr(fill);
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_BEQ, 0, 0, 3));	// Forward to 20
		put_instr(i_type(mips_pkg::OP_SW, 0, 1, 42));
		put_instr(fill);
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_BEQ, 0, 0, -4));	// Back to 17
		release_reset("branch");
		run_cycles(BRANCH_CYCLES);
		for (int i = 0; i < 13; i++)
			check_pc("branch", i, trace[i]);
		check_store_count("branch", 1);
		expect_store("branch", 0, 42, 32'd5);
	endtask

	task automatic jump_test();
		int trace [10] = '{0, 1, 4, 8, 9, 12, 13, 16, 17, 14};
		mips_pkg::word_t fill;
		fill = i_type(mips_pkg::OP_SW, 0, 0, 50);
		begin_test();
		put_instr(i_type(mips_pkg::OP_ORI, 0, 1, 12));
		put_instr(j_type(mips_pkg::OP_J, 4));
		put_instr(fill);
		put_instr(fill);
		put_instr(j_type(mips_pkg::OP_JAL, 8));	// Links 5
		put_instr(fill);
		put_instr(fill);
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_SW, 0, 31, 60));
		put_instr(r_type(mips_pkg::FN_JR, 1, 0, 0));	// To 12
		put_instr(fill);
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_ORI, 0, 2, 16));
		put_instr(r_type(mips_pkg::FN_JALR, 2, 0, 31));	// To 16, links 14
		put_instr(i_type(mips_pkg::OP_SW, 0, 2, 62));
		put_instr(fill);
		put_instr(i_type(mips_pkg::OP_SW, 0, 31, 61));
		put_instr(r_type(mips_pkg::FN_JR, 31, 0, 0));	// Return to 14
		release_reset("jump");
		run_cycles(JUMP_CYCLES);
		for (int i = 0; i < 10; i++)
			check_pc("jump", i, trace[i]);
		check_store_count("jump", 3);
		expect_store("jump jal link", 0, 60, 32'd5);
		expect_store("jump jalr link", 1, 61, 32'd14);
		expect_store("jump return", 2, 62, 32'd16);
	endtask

	task automatic movn_test();
		logic [15:0] v1;
		logic [15:0] v5;
		v1 = 16'($random(seed));
		v5 = v1 ^ 16'h5a5a;			// Always differs from v1
		begin_test();
		put_instr(i_type(mips_pkg::OP_ORI, 0, 1, int'(v1)));
		put_instr(i_type(mips_pkg::OP_ORI, 0, 3, 1));
		put_instr(i_type(mips_pkg::OP_ORI, 0, 5, int'(v5)));
		put_instr(r_type(mips_pkg::FN_MOVN, 1, 3, 4));	// rt non-zero, moves
		put_instr(r_type(mips_pkg::FN_MOVN, 1, 0, 5));	// rt zero, keeps r5
		put_instr(i_type(mips_pkg::OP_SW, 0, 4, 70));
		put_instr(i_type(mips_pkg::OP_SW, 0, 5, 71));
		release_reset("movn");
		run_cycles(MOVN_CYCLES);
		check_store_count("movn", 2);
		expect_store("movn taken", 0, 70, {16'b0, v1});
		expect_store("movn kept", 1, 71, {16'b0, v5});
	endtask

	task automatic multiply_test();
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t c;
		mips_pkg::word_t d;
		logic [63:0] p_s;
		logic [63:0] p_u;
		logic [63:0] acc;
		mips_pkg::word_t mul_lo;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		d = $random(seed);
		p_s = wide_product(a, b, 1'b1);
		p_u = wide_product(a, b, 1'b0);
		acc = p_u + wide_product(c, d, 1'b1) - wide_product(a, d, 1'b0);	// MADD then MSUBU
		mul_lo = c * b;
		begin_test();
		load_const(1, a);
		load_const(2, b);
		load_const(3, c);
		load_const(4, d);
		put_instr(r_type(mips_pkg::FN_MULT, 1, 2, 0));
		put_instr(r_type(mips_pkg::FN_MFHI, 0, 0, 5));
		put_instr(r_type(mips_pkg::FN_MFLO, 0, 0, 6));
		put_instr(i_type(mips_pkg::OP_SW, 0, 5, 80));
		put_instr(i_type(mips_pkg::OP_SW, 0, 6, 81));
		put_instr(r_type(mips_pkg::FN_MULTU, 1, 2, 0));
		put_instr(r_type(mips_pkg::FN_MFHI, 0, 0, 5));
		put_instr(r_type(mips_pkg::FN_MFLO, 0, 0, 6));
		put_instr(i_type(mips_pkg::OP_SW, 0, 5, 82));
		put_instr(i_type(mips_pkg::OP_SW, 0, 6, 83));
		put_instr(sp2_type(mips_pkg::FN_MADD, 3, 4, 0));	// Adds onto MULTU result
		put_instr(sp2_type(mips_pkg::FN_MSUBU, 1, 4, 0));
		put_instr(r_type(mips_pkg::FN_MFHI, 0, 0, 5));
		put_instr(r_type(mips_pkg::FN_MFLO, 0, 0, 6));
		put_instr(i_type(mips_pkg::OP_SW, 0, 5, 84));
		put_instr(i_type(mips_pkg::OP_SW, 0, 6, 85));
		put_instr(sp2_type(mips_pkg::FN_MUL, 3, 2, 7));	// HI/LO left alone
		put_instr(r_type(mips_pkg::FN_MFLO, 0, 0, 6));
		put_instr(i_type(mips_pkg::OP_SW, 0, 7, 86));
		put_instr(i_type(mips_pkg::OP_SW, 0, 6, 87));
		release_reset("multiply");
		run_cycles(MUL_CYCLES);
		check_store_count("multiply", 8);
		expect_store("mult hi", 0, 80, p_s[63:32]);
		expect_store("mult lo", 1, 81, p_s[31:0]);
		expect_store("multu hi", 2, 82, p_u[63:32]);
		expect_store("multu lo", 3, 83, p_u[31:0]);
		expect_store("madd msubu hi", 4, 84, acc[63:32]);
		expect_store("madd msubu lo", 5, 85, acc[31:0]);
		expect_store("mul", 6, 86, mul_lo);
		expect_store("mul keeps lo", 7, 87, acc[31:0]);
	endtask

	initial
	begin
		reset = 1'b1;
		errors = 0;
		checks = 0;
		prog_len = 0;
		seed = 82;
		reset_hold_test();
		alu_test();
		memory_test();
		branch_test();
		jump_test();
		movn_test();
		multiply_test();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- build.f
mips_pkg.sv
control_unit.sv
alu_control.sv
alu.sv
reg_file.sv
mul_unit.sv
mips_core.sv
tb_mips_core.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = tb_mips_core
FILE_LIST = build.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
